//--- verilog.f
design/bp_mem_pkg.sv
design/bp_mem_slice.sv
design/bp_mem_concentrator.sv
design/bp_mem_resp_router.sv
design/bp_mem_complex.sv
tests/bp_mem_complex_tb.sv

//--- Makefile
TOP := bp_mem_complex_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

obj_dir/V$(TOP): verilog.f design/*.sv tests/*.sv
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir

# the run passes only if the pass message shows up as a line of its own
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

//--- tests/bp_mem_complex_tb.sv
`timescale 1ns/1ps

module bp_mem_complex_tb;

  localparam int mc_x_dim_lp = 2;
  localparam int period_lp   = 40;
  localparam int n_rows_lp   = 12;
  localparam int aw_lp       = bp_mem_pkg::addr_width_gp;

  typedef struct packed
  {
    logic [1:0]                col;
    bp_mem_pkg::mem_opcode_e   op;
    logic [aw_lp-1:0]          addr;
    logic [31:0]               data;
  } row_s;

  // each column keeps to its own addresses, so its reads only see its own writes
  localparam row_s rows_lp [n_rows_lp] = '{
    '{2'd0, bp_mem_pkg::e_mem_wr, 26'h000_0010, 32'h1111_0001}
    , '{2'd1, bp_mem_pkg::e_mem_wr, 26'h000_0200, 32'h2222_0001}
    , '{2'd0, bp_mem_pkg::e_mem_rd, 26'h000_0010, 32'h0}
    , '{2'd1, bp_mem_pkg::e_mem_rd, 26'h000_0204, 32'h0}
    , '{2'd0, bp_mem_pkg::e_mem_wr, 26'h000_0014, 32'h1111_0002}
    , '{2'd1, bp_mem_pkg::e_mem_wr, 26'h000_0200, 32'h2222_0002}
    , '{2'd0, bp_mem_pkg::e_mem_rd, 26'h000_0018, 32'h0}
    , '{2'd1, bp_mem_pkg::e_mem_rd, 26'h000_0200, 32'h0}
    , '{2'd0, bp_mem_pkg::e_mem_rd, 26'h000_0014, 32'h0}
    , '{2'd1, bp_mem_pkg::e_mem_wr, 26'h000_0208, 32'h3333_0003}
    , '{2'd0, bp_mem_pkg::e_mem_wr, 26'h000_0010, 32'h4444_0004}
    , '{2'd0, bp_mem_pkg::e_mem_rd, 26'h000_0010, 32'h0}
  };

  logic                                      clk;
  logic                                      rst_n;
  bp_mem_pkg::mem_link_s [mc_x_dim_lp-1:0]   mem_cmd_link;
  logic [mc_x_dim_lp-1:0]                    mem_cmd_ready_and;
  bp_mem_pkg::mem_link_s                     dram_cmd_link;
  logic                                      dram_cmd_ready_and;
  bp_mem_pkg::mem_link_s                     dram_resp_link;
  logic                                      dram_resp_ready_and;
  bp_mem_pkg::mem_link_s [mc_x_dim_lp-1:0]   mem_resp_link;
  logic [mc_x_dim_lp-1:0]                    mem_resp_ready_and;

  integer                                    seed = 32'h26db_9588;
  logic [31:0]                               cmd_exp_q [mc_x_dim_lp][$];
  logic [31:0]                               resp_exp_q [mc_x_dim_lp][$];
  logic [31:0]                               resp_q [$];
  logic [31:0]                               dram_mem [logic [aw_lp-1:0]];
  int                                        in_left [mc_x_dim_lp] = '{default: 0};
  int                                        hdr_in [mc_x_dim_lp] = '{default: 0};
  int                                        hdr_out [mc_x_dim_lp] = '{default: 0};
  int                                        dram_left = 0;
  int                                        open_col = 0;
  int                                        expect_col = -1;
  bp_mem_pkg::mem_hdr_s                      cur_hdr;
  logic [31:0]                               cur_data;

  bp_mem_complex #(.mc_x_dim_p(mc_x_dim_lp)) dut_i
    (.clk_i(clk)
     ,.rst_n_i(rst_n)
     ,.mem_cmd_link_i(mem_cmd_link)
     ,.mem_cmd_ready_and_o(mem_cmd_ready_and)
     ,.dram_cmd_link_o(dram_cmd_link)
     ,.dram_cmd_ready_and_i(dram_cmd_ready_and)
     ,.dram_resp_link_i(dram_resp_link)
     ,.dram_resp_ready_and_o(dram_resp_ready_and)
     ,.mem_resp_link_o(mem_resp_link)
     ,.mem_resp_ready_and_i(mem_resp_ready_and)
     );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopping the run");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
      fail_run($sformatf("** Error: %s expected %h actual %h", name, expected, actual));
  endtask

  function automatic logic [31:0] make_hdr(input bp_mem_pkg::mem_opcode_e op,
                                           input logic [1:0] len, input logic [1:0] cid,
                                           input logic [aw_lp-1:0] addr);
    bp_mem_pkg::mem_flit_u f;
    f.hdr.opcode = op;
    f.hdr.len    = len;
    f.hdr.cid    = cid;
    f.hdr.addr   = addr;
    return f.data;
  endfunction

  // last earlier write by the same column to the same address, else the fill pattern
  function automatic logic [31:0] read_value(input int r);
    logic [31:0] value;
    value = 32'(rows_lp[r].addr) ^ 32'h5a5a_5a5a;
    for (int i = 0; i < r; i++)
      if (rows_lp[i].col == rows_lp[r].col && rows_lp[i].op == bp_mem_pkg::e_mem_wr
          && rows_lp[i].addr == rows_lp[r].addr)
        value = rows_lp[i].data;
    return value;
  endfunction

  task automatic load_expectations();
    int  c;
    logic wr;
    for (int r = 0; r < n_rows_lp; r++)
      begin
        c  = int'(rows_lp[r].col);
        wr = (rows_lp[r].op == bp_mem_pkg::e_mem_wr);
        cmd_exp_q[c].push_back(make_hdr(rows_lp[r].op, wr ? 2'd1 : 2'd0, 2'(c), rows_lp[r].addr));
        resp_exp_q[c].push_back(make_hdr(rows_lp[r].op, wr ? 2'd0 : 2'd1, 2'(c), rows_lp[r].addr));
        if (wr)
          cmd_exp_q[c].push_back(rows_lp[r].data);
        else
          resp_exp_q[c].push_back(read_value(r));
      end
  endtask

  task automatic send_flit(input int c, input logic [31:0] word);
    mem_cmd_link[c].v         = 1'b1;
    mem_cmd_link[c].flit.data = word;
    do
      @(negedge clk);
    while (!mem_cmd_ready_and[c]);
    @(posedge clk);
    #2;
    mem_cmd_link[c].v = 1'b0;
  endtask

  task automatic drive_column(input int c);
    int gap;
    for (int r = 0; r < n_rows_lp; r++)
      if (int'(rows_lp[r].col) == c)
        begin
          gap = int'($unsigned($random(seed)) % 3);
          repeat (gap)
            begin
              @(posedge clk);
              #2;
            end
          // a wrong cid goes in so the slice has to overwrite it
          send_flit(c, make_hdr(rows_lp[r].op, (rows_lp[r].op == bp_mem_pkg::e_mem_wr) ? 2'd1 : 2'd0,
                                2'(3 - c), rows_lp[r].addr));
          if (rows_lp[r].op == bp_mem_pkg::e_mem_wr)
            send_flit(c, rows_lp[r].data);
        end
  endtask

  task automatic answer_command();
    logic [31:0] rd_data;
    if (cur_hdr.opcode == bp_mem_pkg::e_mem_wr)
      begin
        dram_mem[cur_hdr.addr] = cur_data;
        resp_q.push_back(make_hdr(cur_hdr.opcode, 2'd0, cur_hdr.cid, cur_hdr.addr));
      end
    else
      begin
        rd_data = dram_mem.exists(cur_hdr.addr) ? dram_mem[cur_hdr.addr]
                                                : 32'(cur_hdr.addr) ^ 32'h5a5a_5a5a;
        resp_q.push_back(make_hdr(cur_hdr.opcode, 2'd1, cur_hdr.cid, cur_hdr.addr));
        resp_q.push_back(rd_data);
      end
  endtask

  initial
    begin
      clk = 1'b0;
      forever #(period_lp / 2) clk = ~clk;
    end

  initial
    begin
      #((n_rows_lp * 20 + 200) * period_lp);
      fail_run("the run timed out before every response came back");
    end

  // random stalls on the DRAM command link and on the column response links
  initial
    begin
      dram_cmd_ready_and = 1'b0;
      mem_resp_ready_and = '0;
      forever
        begin
          @(posedge clk);
          #2;
          dram_cmd_ready_and = (($random(seed) & 3) != 0);
          mem_resp_ready_and = 2'($random(seed));
        end
    end

  initial
    begin
      dram_resp_link = '0;
      forever
        begin
          @(posedge clk);
          #2;
          if (resp_q.size() == 0)
            dram_resp_link.v = 1'b0;
          else
            begin
              dram_resp_link.v         = 1'b1;
              dram_resp_link.flit.data = resp_q.pop_front();
              do
                @(negedge clk);
              while (!dram_resp_ready_and);
            end
        end
    end

  // all links are sampled mid-cycle, where a transfer is already decided
  always @(negedge clk)
    begin
      bp_mem_pkg::mem_flit_u f;
      int nxt;
      if (rst_n)
        begin
          for (int c = 0; c < mc_x_dim_lp; c++)
            begin
              if (mem_cmd_link[c].v && mem_cmd_ready_and[c])
                begin
                  if (in_left[c] == 0)
                    begin
                      hdr_in[c]++;
                      in_left[c] = int'(mem_cmd_link[c].flit.hdr.len);
                    end
                  else
                    in_left[c]--;
                end
              if (mem_resp_link[c].v && mem_resp_ready_and[c])
                begin
                  if (resp_exp_q[c].size() == 0)
                    fail_run($sformatf("column %0d got a response flit it never asked for", c));
                  check_value($sformatf("response column %0d", c), resp_exp_q[c].pop_front(),
                              mem_resp_link[c].flit.data);
                end
            end
          if (dram_cmd_link.v && dram_cmd_ready_and)
            begin
              f = dram_cmd_link.flit;
              if (dram_left == 0)
                begin
                  if (int'(f.hdr.cid) >= mc_x_dim_lp)
                    fail_run("a DRAM command header named a column that does not exist");
                  open_col = int'(f.hdr.cid);
                  if (expect_col >= 0)
                    check_value("round-robin grant", 32'(expect_col), 32'(open_col));
                  hdr_out[open_col]++;
                  cur_hdr   = f.hdr;
                  dram_left = int'(f.hdr.len);
                end
              else
                begin
                  cur_data = f.data;
                  dram_left--;
                end
              if (cmd_exp_q[open_col].size() == 0)
                fail_run("the DRAM command link carried a flit that no column sent");
              check_value($sformatf("dram command column %0d", open_col),
                          cmd_exp_q[open_col].pop_front(), f.data);
              if (dram_left == 0)
                begin
                  answer_command();
                  nxt        = (open_col + 1) % mc_x_dim_lp;
                  expect_col = (hdr_in[nxt] > hdr_out[nxt]) ? nxt : -1;
                end
            end
        end
    end

  initial
    begin
      mem_cmd_link = '0;
      rst_n        = 1'b0;
      load_expectations();
      repeat (8) @(posedge clk);
      #2;
      rst_n = 1'b1;
      for (int i = 0; i < 4; i++)
        begin
          @(negedge clk);
          check_value("reset dram command valid", 32'd0, 32'(dram_cmd_link.v));
          for (int c = 0; c < mc_x_dim_lp; c++)
            check_value($sformatf("reset column %0d response valid", c), 32'd0,
                        32'(mem_resp_link[c].v));
        end
      @(posedge clk);
      #2;
      fork
        drive_column(0);
        drive_column(1);
      join
      while (resp_exp_q[0].size() + resp_exp_q[1].size() != 0)
        @(posedge clk);
      repeat (10) @(posedge clk);
      check_value("command flits never seen", 32'd0, 32'(cmd_exp_q[0].size() + cmd_exp_q[1].size()));
      check_value("responses left in the DRAM model", 32'd0, 32'(resp_q.size()));
      $display("All checks passed");
      $finish;
    end

endmodule

//--- design/bp_mem_complex.sv
`timescale 1ns/1ps

module bp_mem_complex
 #(parameter int mc_x_dim_p = 2)
  (input                                            clk_i
   , input                                          rst_n_i

   , input  bp_mem_pkg::mem_link_s [mc_x_dim_p-1:0] mem_cmd_link_i
   , output logic [mc_x_dim_p-1:0]                  mem_cmd_ready_and_o

   , output bp_mem_pkg::mem_link_s                  dram_cmd_link_o
   , input                                          dram_cmd_ready_and_i

   , input  bp_mem_pkg::mem_link_s                  dram_resp_link_i
   , output logic                                   dram_resp_ready_and_o

   , output bp_mem_pkg::mem_link_s [mc_x_dim_p-1:0] mem_resp_link_o
   , input  [mc_x_dim_p-1:0]                        mem_resp_ready_and_i
   );

  bp_mem_pkg::mem_link_s [mc_x_dim_p-1:0]   slice_link_lo;
  logic [mc_x_dim_p-1:0]                    slice_ready_and_li;

  for (genvar i = 0; i < mc_x_dim_p; i++)
    begin : slice
      bp_mem_slice
       #(.column_p(i))
       slice_i
        (.clk_i(clk_i)
         ,.rst_n_i(rst_n_i)

         ,.link_i(mem_cmd_link_i[i])
         ,.ready_and_o(mem_cmd_ready_and_o[i])

         ,.link_o(slice_link_lo[i])
         ,.ready_and_i(slice_ready_and_li[i])
         );
    end

  bp_mem_concentrator
   #(.mc_x_dim_p(mc_x_dim_p))
   concentrator_i
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)

     ,.links_i(slice_link_lo)
     ,.ready_and_o(slice_ready_and_li)

     ,.link_o(dram_cmd_link_o)
     ,.ready_and_i(dram_cmd_ready_and_i)
     );

  // responses bypass the slices and go straight back by cid
  bp_mem_resp_router
   #(.mc_x_dim_p(mc_x_dim_p))
   resp_router_i
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)

     ,.link_i(dram_resp_link_i)
     ,.ready_and_o(dram_resp_ready_and_o)

     ,.links_o(mem_resp_link_o)
     ,.ready_and_i(mem_resp_ready_and_i)
     );

endmodule

//--- design/bp_mem_resp_router.sv
`timescale 1ns/1ps

module bp_mem_resp_router
 #(parameter int mc_x_dim_p = 2)
  (input                                            clk_i
   , input                                          rst_n_i

   , input  bp_mem_pkg::mem_link_s                  link_i
   , output logic                                   ready_and_o

   , output bp_mem_pkg::mem_link_s [mc_x_dim_p-1:0] links_o
   , input  [mc_x_dim_p-1:0]                        ready_and_i
   );

  logic                                     busy_r;
  logic [bp_mem_pkg::cid_width_gp-1:0]      route_r;
  logic [bp_mem_pkg::len_width_gp-1:0]      left_r;
  logic [bp_mem_pkg::cid_width_gp-1:0]      route;
  logic                                     xfer;

  assign route = busy_r ? route_r : link_i.flit.hdr.cid;
  assign xfer  = link_i.v & ready_and_o;

  always_comb
    begin
      ready_and_o = 1'b0;
      for (int i = 0; i < mc_x_dim_p; i++)
        begin
          links_o[i].v    = link_i.v & (route == i);
          links_o[i].flit = link_i.flit;
          if (route == i)
            ready_and_o = ready_and_i[i];
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          busy_r  <= 1'b0;
          route_r <= '0;
          left_r  <= '0;
        end
      else if (xfer)
        begin
          if (!busy_r)
            begin
              route_r <= link_i.flit.hdr.cid;
              left_r  <= link_i.flit.hdr.len;
              busy_r  <= (link_i.flit.hdr.len != '0);
            end
          else
            begin
              left_r <= left_r - 1'b1;
              busy_r <= (left_r != 1);               // clears on the last data flit
            end
        end
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (link_i.v && !busy_r) |-> (link_i.flit.hdr.cid < mc_x_dim_p));

endmodule

//--- design/bp_mem_concentrator.sv
`timescale 1ns/1ps

module bp_mem_concentrator
 #(parameter int mc_x_dim_p = 2)
  (input                                            clk_i
   , input                                          rst_n_i

   , input  bp_mem_pkg::mem_link_s [mc_x_dim_p-1:0] links_i
   , output logic [mc_x_dim_p-1:0]                  ready_and_o

   , output bp_mem_pkg::mem_link_s                  link_o
   , input                                          ready_and_i
   );

  localparam int idx_width_lp = (mc_x_dim_p > 1) ? $clog2(mc_x_dim_p) : 1;

  logic [idx_width_lp-1:0]                  ptr_r;
  logic [idx_width_lp-1:0]                  grant_r;
  logic                                     busy_r;
  logic [bp_mem_pkg::len_width_gp-1:0]      left_r;

  logic [idx_width_lp-1:0]                  pick;
  logic [idx_width_lp-1:0]                  sel;
  logic [idx_width_lp-1:0]                  sel_next;
  logic                                     xfer;

  // first requesting input at or after the round-robin pointer
  always_comb
    begin
      int unsigned idx;
      logic        found;
      found = 1'b0;
      pick  = ptr_r;
      for (int i = 0; i < mc_x_dim_p; i++)
        begin
          idx = (int'(ptr_r) + i) % mc_x_dim_p;
          if (!found && links_i[idx].v)
            begin
              found = 1'b1;
              pick  = idx[idx_width_lp-1:0];
            end
        end
    end

  assign sel      = busy_r ? grant_r : pick;   // locked to the open packet
  assign sel_next = (sel == idx_width_lp'(mc_x_dim_p - 1)) ? '0 : sel + 1'b1;
  assign xfer     = link_o.v & ready_and_i;

  always_comb
    begin
      link_o = links_i[sel];
      for (int i = 0; i < mc_x_dim_p; i++)
        ready_and_o[i] = ready_and_i & (sel == idx_width_lp'(i));
    end

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          ptr_r   <= '0;
          grant_r <= '0;
          busy_r  <= 1'b0;
          left_r  <= '0;
        end
      else if (xfer)
        begin
          if (!busy_r)
            begin
              grant_r <= pick;
              left_r  <= link_o.flit.hdr.len;
              if (link_o.flit.hdr.len == '0)
                ptr_r <= sel_next;                    // header-only packet ends here
              else
                busy_r <= 1'b1;
            end
          else
            begin
              left_r <= left_r - 1'b1;
              if (left_r == 1)
                begin
                  busy_r <= 1'b0;
                  ptr_r  <= sel_next;
                end
            end
        end
    end

  // the input that sent the header keeps the link for as long as the packet is open
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_r |-> (sel == $past(sel)));

endmodule

//--- design/bp_mem_slice.sv
`timescale 1ns/1ps

module bp_mem_slice
 #(parameter int column_p = 0)
  (input                           clk_i
   , input                         rst_n_i

   , input  bp_mem_pkg::mem_link_s link_i
   , output logic                  ready_and_o

   , output bp_mem_pkg::mem_link_s link_o
   , input                         ready_and_i
   );

  localparam logic [bp_mem_pkg::cid_width_gp-1:0] cid_lp =
    column_p[bp_mem_pkg::cid_width_gp-1:0];

  bp_mem_pkg::mem_flit_u [1:0]              mem_r;
  bp_mem_pkg::mem_flit_u                    stamped_flit;
  logic                                     wr_ptr_r;
  logic                                     rd_ptr_r;
  logic [1:0]                               count_r;
  logic [bp_mem_pkg::len_width_gp-1:0]      left_r;
  logic                                     enq;
  logic                                     deq;

  assign ready_and_o = (count_r != 2'd2);
  assign enq         = link_i.v & ready_and_o;
  assign deq         = link_o.v & ready_and_i;

  // a zero count of flits left means the incoming flit is a header
  always_comb
    begin
      stamped_flit = link_i.flit;
      if (left_r == '0)
        stamped_flit.hdr.cid = cid_lp;
    end

  always_comb
    begin
      link_o.v    = (count_r != 2'd0);
      link_o.flit = mem_r[rd_ptr_r];
    end

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          wr_ptr_r <= 1'b0;
          rd_ptr_r <= 1'b0;
          count_r  <= 2'd0;
          left_r   <= '0;
        end
      else
        begin
          if (enq)
            begin
              wr_ptr_r <= ~wr_ptr_r;
              left_r   <= (left_r == '0) ? link_i.flit.hdr.len : left_r - 1'b1;
            end
          if (deq)
            rd_ptr_r <= ~rd_ptr_r;
          count_r <= count_r + {1'b0, enq} - {1'b0, deq};
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (enq)
        mem_r[wr_ptr_r] <= stamped_flit;
    end

  // a stalled output flit must not change under the consumer
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (link_o.v && !ready_and_i) |=> (link_o.v && $stable(link_o.flit)));

endmodule

//--- design/bp_mem_pkg.sv
package bp_mem_pkg;

  localparam int flit_width_gp = 32;
  localparam int cid_width_gp  = 2;                  // at most four columns
  localparam int len_width_gp  = 2;

  // opcode, len and cid take the top six bits and the address fills the rest
  localparam int addr_width_gp = flit_width_gp - 2 - len_width_gp - cid_width_gp;

  typedef enum logic [1:0]
  {
    e_mem_rd = 2'b00
    , e_mem_wr = 2'b01
  } mem_opcode_e;

  typedef struct packed
  {
    mem_opcode_e                opcode;
    logic [len_width_gp-1:0]    len;           // number of data flits after the header
    logic [cid_width_gp-1:0]    cid;           // column that owns the packet
    logic [addr_width_gp-1:0]   addr;
  } mem_hdr_s;

  // the same word is a header at the start of a packet and raw data after it
  typedef union packed
  {
    mem_hdr_s                   hdr;
    logic [flit_width_gp-1:0]   data;
  } mem_flit_u;

  typedef struct packed
  {
    logic                       v;
    mem_flit_u                  flit;
  } mem_link_s;

endpackage
